// File: include/router_defs.svh
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// router geometry
`define ROUTER_PORTS 5
`define COORD_W      4      // bits per mesh coordinate
`define DATA_W       32

// input buffer, also the credit count a sender starts with
`define BUF_DEPTH    4
`define CRED_W       3      // must hold BUF_DEPTH

// port numbering
`define PORT_LOCAL   0
`define PORT_EAST    1
`define PORT_NORTH   2
`define PORT_WEST    3
`define PORT_SOUTH   4

`endif

// File: rtl/router_pkg.sv
`include "router_defs.svh"

package router_pkg;

    // one flit on the link
    // head flit: dest x in data[COORD_W-1:0], dest y in the next COORD_W bits
    typedef struct packed {
        logic               head;
        logic               tail;
        logic [`DATA_W-1:0] data;
    } flit_t;

    // forward half of a channel, credits travel back separately
    typedef struct packed {
        logic  valid;
        flit_t flit;
    } link_t;

    // one-hot port vector, used for route requests and grants
    typedef logic [`ROUTER_PORTS-1:0] port_sel_t;

endpackage

// File: rtl/input_port.sv
`include "router_defs.svh"

module input_port #(
    parameter int MY_X = 0,
    parameter int MY_Y = 0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  router_pkg::link_t     link_in,
    input  logic                  pop,
    output logic                  credit_out,
    output router_pkg::flit_t     head_flit,
    output logic                  head_valid,
    output router_pkg::port_sel_t request
);

    localparam int PTR_W = $clog2(`BUF_DEPTH);
    localparam logic [`COORD_W-1:0] X_ADDR = `COORD_W'(MY_X);
    localparam logic [`COORD_W-1:0] Y_ADDR = `COORD_W'(MY_Y);

    router_pkg::flit_t     mem [`BUF_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [`CRED_W-1:0]    count;
    logic [`COORD_W-1:0]   dest_x;
    logic [`COORD_W-1:0]   dest_y;
    router_pkg::port_sel_t xy_route;
    router_pkg::port_sel_t route_q;

    // upstream only writes when it holds a credit, so no full check here
    always_ff @(posedge clk) begin
        if (link_in.valid) begin
            mem[wr_ptr] <= link_in.flit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_out <= 1'b0;
        end else begin
            if (link_in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;     // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count      <= count + `CRED_W'(link_in.valid) - `CRED_W'(pop);
            credit_out <= pop;               // one slot back upstream per pop
        end
    end

    assign head_flit  = mem[rd_ptr];
    assign head_valid = (count != '0);

    assign dest_x = head_flit.data[`COORD_W-1:0];
    assign dest_y = head_flit.data[2*`COORD_W-1:`COORD_W];

    // XY routing: x first, then y
    always_comb begin
        xy_route = '0;
        if (dest_x > X_ADDR) begin
            xy_route[`PORT_EAST] = 1'b1;
        end else if (dest_x < X_ADDR) begin
            xy_route[`PORT_WEST] = 1'b1;
        end else if (dest_y > Y_ADDR) begin
            xy_route[`PORT_NORTH] = 1'b1;    // north is increasing y
        end else if (dest_y < Y_ADDR) begin
            xy_route[`PORT_SOUTH] = 1'b1;
        end else begin
            xy_route[`PORT_LOCAL] = 1'b1;
        end
    end

    // body and tail flits follow the route of their head
    always_ff @(posedge clk) begin
        if (reset) begin
            route_q <= '0;
        end else if (pop && head_flit.head) begin
            route_q <= xy_route;
        end
    end

    assign request = head_flit.head ? xy_route : route_q;

endmodule

// File: rtl/switch_allocator.sv
`include "router_defs.svh"

module switch_allocator (
    input  logic                      clk,
    input  logic                      reset,
    input  router_pkg::port_sel_t     request [`ROUTER_PORTS],
    input  logic [`ROUTER_PORTS-1:0]  head_valid,
    input  logic [`ROUTER_PORTS-1:0]  head_is_tail,
    input  logic [`ROUTER_PORTS-1:0]  credit_ok,
    output logic [`ROUTER_PORTS-1:0]  pop,
    output router_pkg::port_sel_t     grant [`ROUTER_PORTS],
    output logic [`ROUTER_PORTS-1:0]  send
);

    localparam int P     = `ROUTER_PORTS;
    localparam int IDX_W = $clog2(P);

    router_pkg::port_sel_t cand  [P];    // requests per output, indexed by input
    router_pkg::port_sel_t win   [P];
    router_pkg::port_sel_t owner [P];
    logic [P-1:0]          locked;
    logic [IDX_W-1:0]      rr_ptr  [P];
    logic [IDX_W-1:0]      win_idx [P];

    always_comb begin
        for (int o = 0; o < P; o++) begin
            win[o]     = '0;
            win_idx[o] = rr_ptr[o];
            // a locked output listens only to the input that holds the packet
            for (int i = 0; i < P; i++) begin
                cand[o][i] = head_valid[i] & request[i][o] & credit_ok[o]
                           & (~locked[o] | owner[o][i]);
            end
            // walk backwards so the candidate nearest the pointer is kept
            for (int k = P - 1; k >= 0; k--) begin
                if (cand[o][(int'(rr_ptr[o]) + k) % P]) begin
                    win[o]     = '0;
                    win[o][(int'(rr_ptr[o]) + k) % P] = 1'b1;
                    win_idx[o] = IDX_W'((int'(rr_ptr[o]) + k) % P);
                end
            end
        end
    end

    // each input requests one output, so at most one win per input
    always_comb begin
        pop = '0;
        for (int o = 0; o < P; o++) begin
            pop = pop | win[o];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            locked <= '0;
            send   <= '0;
            for (int o = 0; o < P; o++) begin
                owner[o]  <= '0;
                rr_ptr[o] <= '0;
                grant[o]  <= '0;
            end
        end else begin
            for (int o = 0; o < P; o++) begin
                grant[o] <= win[o];          // stage 2 boundary
                send[o]  <= |win[o];
                if (|win[o]) begin
                    rr_ptr[o] <= (win_idx[o] == IDX_W'(P - 1)) ? '0 : win_idx[o] + 1'b1;
                    owner[o]  <= win[o];
                    // held from head to tail, a single-flit packet never locks
                    locked[o] <= ~|(win[o] & head_is_tail);
                end
            end
        end
    end

endmodule

// File: rtl/output_port.sv
`include "router_defs.svh"

module output_port (
    input  logic              clk,
    input  logic              reset,
    input  logic              send,
    input  router_pkg::flit_t flit_in,
    input  logic              credit_in,
    output router_pkg::link_t link_out,
    output logic              credit_ok
);

    logic [`CRED_W-1:0] credits;     // free slots in the downstream buffer
    logic               valid_q;
    router_pkg::flit_t  flit_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= `CRED_W'(`BUF_DEPTH);
            valid_q <= 1'b0;
        end else begin
            credits <= credits - `CRED_W'(send) + `CRED_W'(credit_in);
            valid_q <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            flit_q <= flit_in;
        end
    end

    // a send in flight this cycle already spends one credit,
    // so the allocator needs a second one to grant again
    assign credit_ok = (credits > `CRED_W'(send));

    assign link_out = '{valid: valid_q, flit: flit_q};

endmodule

// File: rtl/crossbar.sv
`include "router_defs.svh"

module crossbar (
    input  router_pkg::port_sel_t grant    [`ROUTER_PORTS],
    input  router_pkg::flit_t     flit_in  [`ROUTER_PORTS],
    output router_pkg::flit_t     flit_out [`ROUTER_PORTS]
);

    localparam int P = `ROUTER_PORTS;

    // grant rows are one-hot over inputs
    always_comb begin
        for (int o = 0; o < P; o++) begin
            flit_out[o] = '0;
            for (int i = 0; i < P; i++) begin
                if (grant[o][i]) begin
                    flit_out[o] = flit_in[i];
                end
            end
        end
    end

endmodule

// File: rtl/mesh_router.sv
`include "router_defs.svh"

module mesh_router #(
    parameter int MY_X = 0,
    parameter int MY_Y = 0
) (
    input  logic                     clk,
    input  logic                     reset,
    input  router_pkg::link_t        link_in  [`ROUTER_PORTS],
    input  logic [`ROUTER_PORTS-1:0] credit_in,
    output router_pkg::link_t        link_out [`ROUTER_PORTS],
    output logic [`ROUTER_PORTS-1:0] credit_out
);

    localparam int P = `ROUTER_PORTS;

    router_pkg::flit_t     head_flit [P];
    router_pkg::flit_t     flit_q    [P];    // stage 2 data per input
    router_pkg::flit_t     xbar_flit [P];
    router_pkg::port_sel_t request   [P];
    router_pkg::port_sel_t grant     [P];
    logic [P-1:0]          head_valid;
    logic [P-1:0]          head_is_tail;
    logic [P-1:0]          pop;
    logic [P-1:0]          send;
    logic [P-1:0]          credit_ok;

    for (genvar i = 0; i < P; i++) begin : g_port
        input_port #(
            .MY_X (MY_X),
            .MY_Y (MY_Y)
        ) in_port_i (
            .clk        (clk),
            .reset      (reset),
            .link_in    (link_in[i]),
            .pop        (pop[i]),
            .credit_out (credit_out[i]),
            .head_flit  (head_flit[i]),
            .head_valid (head_valid[i]),
            .request    (request[i])
        );

        assign head_is_tail[i] = head_flit[i].tail;

        // popped flit waits here for the crossbar
        always_ff @(posedge clk) begin
            if (pop[i]) begin
                flit_q[i] <= head_flit[i];
            end
        end

        output_port out_port_i (
            .clk       (clk),
            .reset     (reset),
            .send      (send[i]),
            .flit_in   (xbar_flit[i]),
            .credit_in (credit_in[i]),
            .link_out  (link_out[i]),
            .credit_ok (credit_ok[i])
        );
    end

    switch_allocator alloc_i (
        .clk          (clk),
        .reset        (reset),
        .request      (request),
        .head_valid   (head_valid),
        .head_is_tail (head_is_tail),
        .credit_ok    (credit_ok),
        .pop          (pop),
        .grant        (grant),
        .send         (send)
    );

    crossbar xbar_i (
        .grant    (grant),
        .flit_in  (flit_q),
        .flit_out (xbar_flit)
    );

endmodule

// File: verification/mesh_router_asserts.sv
`include "router_defs.svh"

module mesh_router_asserts (
    input logic                     clk,
    input logic                     reset,
    input router_pkg::link_t        link_in  [`ROUTER_PORTS],
    input logic [`ROUTER_PORTS-1:0] send,
    input logic [`ROUTER_PORTS-1:0] credit_in,
    input logic [`ROUTER_PORTS-1:0] credit_out,
    input router_pkg::link_t        link_out [`ROUTER_PORTS]
);

    for (genvar p = 0; p < `ROUTER_PORTS; p++) begin : g_chk
        int   in_flight;    // sent and not yet credited back
        int   held;         // received and not yet credited upstream
        logic pkt_open;

        always_ff @(posedge clk) begin
            if (reset) begin
                in_flight <= 0;
                held      <= 0;
                pkt_open  <= 1'b0;
            end else begin
                in_flight <= in_flight + int'(send[p]) - int'(credit_in[p]);
                held      <= held + int'(link_in[p].valid) - int'(credit_out[p]);
                if (link_out[p].valid) begin
                    pkt_open <= ~link_out[p].flit.tail;
                end
            end
        end

        a_credit_bound: assert property (@(posedge clk) disable iff (reset)
            in_flight <= `BUF_DEPTH)
            else $error("output %0d sent beyond its credits", p);

        // one credit upstream per flit taken in, never more
        a_credit_return: assert property (@(posedge clk) disable iff (reset)
            held >= 0 && held <= `BUF_DEPTH)
            else $error("input %0d credits out of step with its flits", p);

        // head only between packets, body and tail only inside one
        a_wormhole_lock: assert property (@(posedge clk) disable iff (reset)
            link_out[p].valid |-> (link_out[p].flit.head == ~pkt_open))
            else $error("output %0d packets interleaved", p);
    end

endmodule

bind mesh_router mesh_router_asserts asserts_i (.*);

// File: verification/mesh_router_tb.sv
`include "router_defs.svh"

module mesh_router_tb;

    localparam int P        = `ROUTER_PORTS;
    localparam int MY_X     = 2;
    localparam int MY_Y     = 2;
    localparam int PERIOD   = 40;
    localparam int NUM_PKTS = 12;                          // per input
    localparam int MAX_TIME = NUM_PKTS * P * 4 * 40 * PERIOD;

    logic              clk;
    logic              reset;
    router_pkg::link_t link_in  [P];
    logic [P-1:0]      credit_in;
    router_pkg::link_t link_out [P];
    logic [P-1:0]      credit_out;

    router_pkg::flit_t src_q [P][$];       // flits still to send, per input
    router_pkg::flit_t exp_q [P][P][$];    // expected flits by output, then input
    int                due_q [P][$];       // cycles when downstream frees a slot
    int                up_cred   [P];
    int                sent      [P];
    int                returned  [P];
    int                in_flight [P];      // per output, not yet credited back
    int                owner     [P];      // input of the open packet, -1 if none
    int                cycle;
    logic              running;
    integer            seed;

    mesh_router #(.MY_X(MY_X), .MY_Y(MY_Y)) dut_i (.*);

    always #(PERIOD / 2) clk = ~clk;

    // XY order, x first
    function automatic int route_ref(int dx, int dy);
        int port;
        if (dx > MY_X) port = `PORT_EAST;
        else if (dx < MY_X) port = `PORT_WEST;
        else if (dy > MY_Y) port = `PORT_NORTH;
        else if (dy < MY_Y) port = `PORT_SOUTH;
        else port = `PORT_LOCAL;
        return port;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_flit(int o, router_pkg::flit_t got, router_pkg::flit_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t output %0d flit %h, expected %h",
                                    $time, o, got, exp));
        end
    endtask

    task automatic check_credit(string what, int got, int exp);
        if (got != exp) begin
            stop_on_error($sformatf("FAIL t=%0t %s is %0d, expected %0d",
                                    $time, what, got, exp));
        end
    endtask

    task automatic build_packets();
        router_pkg::flit_t f;
        int len;
        int dx;
        int dy;
        int o;
        for (int i = 0; i < P; i++) begin
            for (int p = 0; p < NUM_PKTS; p++) begin
                len = 1 + ($unsigned($random(seed)) % 4);
                dx  = $unsigned($random(seed)) % 4;    // 4x4 mesh around (2,2)
                dy  = $unsigned($random(seed)) % 4;
                o   = route_ref(dx, dy);
                for (int k = 0; k < len; k++) begin
                    f.head = (k == 0);
                    f.tail = (k == len - 1);
                    f.data = $random(seed);
                    if (k == 0) f.data[10:0] = {3'(i), 4'(dy), 4'(dx)};  // source above dest
                    src_q[i].push_back(f);
                    exp_q[o][i].push_back(f);
                end
            end
        end
    endtask

    function automatic bit traffic_done();
        for (int i = 0; i < P; i++) begin
            if (src_q[i].size() != 0 || due_q[i].size() != 0) return 1'b0;
            for (int o = 0; o < P; o++) begin
                if (exp_q[o][i].size() != 0) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // upstream senders, each bound by its credit count
    always @(posedge clk) begin
        for (int i = 0; i < P; i++) begin
            if (credit_out[i] === 1'b1) begin
                up_cred[i]++;
                returned[i]++;
                if (returned[i] > sent[i]) stop_on_error("input returned a credit it never got");
            end
            if (running && src_q[i].size() > 0 && up_cred[i] > 0) begin
                link_in[i] <= '{valid: 1'b1, flit: src_q[i].pop_front()};
                up_cred[i]--;
                sent[i]++;
            end else begin
                link_in[i] <= '0;
            end
        end
    end

    // compare process and downstream buffers
    always @(posedge clk) begin
        router_pkg::flit_t got;
        int src;
        cycle++;
        for (int o = 0; o < P; o++) begin
            credit_in[o] <= 1'b0;
            if (due_q[o].size() > 0 && due_q[o][0] <= cycle) begin
                void'(due_q[o].pop_front());
                credit_in[o] <= 1'b1;
                in_flight[o]--;
            end
            if (!reset && link_out[o].valid) begin
                got = link_out[o].flit;
                if (got.head && owner[o] >= 0) stop_on_error("head flit inside an open packet");
                if (!got.head && owner[o] < 0) stop_on_error("body flit with no open packet");
                src = got.head ? int'(got.data[10:8]) : owner[o];
                if (src >= P || exp_q[o][src].size() == 0) begin
                    stop_on_error($sformatf("FAIL t=%0t output %0d unexpected flit %h",
                                            $time, o, got));
                end
                check_flit(o, got, exp_q[o][src].pop_front());
                owner[o] = got.tail ? -1 : src;
                due_q[o].push_back(cycle + ($unsigned($random(seed)) % 4));
                in_flight[o]++;
                if (in_flight[o] > `BUF_DEPTH) stop_on_error("output overran downstream buffer");
            end
        end
    end

    initial begin
        seed      = 32'h9c7c_3f70;
        clk       = 1'b0;
        reset     = 1'b1;
        running   = 1'b0;
        credit_in = '0;
        cycle     = 0;
        for (int i = 0; i < P; i++) begin
            link_in[i]   = '0;
            up_cred[i]   = `BUF_DEPTH;
            sent[i]      = 0;
            returned[i]  = 0;
            in_flight[i] = 0;
            owner[i]     = -1;
        end
        build_packets();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin                             // idle, nothing may move
            @(posedge clk);
            for (int o = 0; o < P; o++) begin
                if (link_out[o].valid !== 1'b0 || credit_out[o] !== 1'b0) begin
                    stop_on_error("output or credit active after reset with no traffic");
                end
            end
        end
        running <= 1'b1;
        while (!traffic_done()) @(posedge clk);
        repeat (10) @(posedge clk);
        for (int i = 0; i < P; i++) begin
            check_credit($sformatf("credits returned by input %0d", i), returned[i], sent[i]);
        end
        check_credit("output 0 credit count", dut_i.g_port[0].out_port_i.credits, `BUF_DEPTH);
        check_credit("output 1 credit count", dut_i.g_port[1].out_port_i.credits, `BUF_DEPTH);
        check_credit("output 2 credit count", dut_i.g_port[2].out_port_i.credits, `BUF_DEPTH);
        check_credit("output 3 credit count", dut_i.g_port[3].out_port_i.credits, `BUF_DEPTH);
        check_credit("output 4 credit count", dut_i.g_port[4].out_port_i.credits, `BUF_DEPTH);
        $display("STATUS: PASS");
        $finish;
    end

    // watchdog
    initial begin
        #(MAX_TIME);
        $display("watchdog expired before all traffic drained");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// File: all.f
+incdir+include
rtl/router_pkg.sv
rtl/input_port.sv
rtl/switch_allocator.sv
rtl/output_port.sv
rtl/crossbar.sv
rtl/mesh_router.sv
verification/mesh_router_asserts.sv
verification/mesh_router_tb.sv

// File: Bender.yml
package:
  name: mesh_router

export_include_dirs:
  - include

sources:
  - rtl/router_pkg.sv
  - rtl/input_port.sv
  - rtl/switch_allocator.sv
  - rtl/output_port.sv
  - rtl/crossbar.sv
  - rtl/mesh_router.sv
  - target: simulation
    files:
      - verification/mesh_router_asserts.sv
      - verification/mesh_router_tb.sv
